// ==== mouse_soc_pkg.sv ====
// mouse soc shared bus types, access sizes and address map constants
package mouse_soc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////////////////////////////////////////

    // data and address width
    localparam int unsigned XLEN = 32;

    ////////////////////////////////////////////////////////////////////////////
    // bus request and response
    ////////////////////////////////////////////////////////////////////////////

    // access size as log2 of the byte count
    typedef enum logic [1:0] {
        SIZ_BYTE = 2'd0,
        SIZ_HALF = 2'd1,
        SIZ_WORD = 2'd2
    } tcb_siz_e;

    // request payload
    typedef struct packed {
        // write enable
        logic            wen;
        // byte address
        logic [XLEN-1:0] adr;
        // log size
        tcb_siz_e        siz;
        // write data, right aligned for sub-word writes
        logic [XLEN-1:0] wdt;
    } tcb_req_t;

    // response payload
    typedef struct packed {
        // whole addressed word
        logic [XLEN-1:0] rdt;
        // error status
        logic            err;
    } tcb_rsp_t;

    ////////////////////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////////////////////

    // data memory, 64kB window
    localparam logic [XLEN-1:0] MEM_BASE = 32'h8000_0000;
    // peripherals, 64kB window
    localparam logic [XLEN-1:0] PER_BASE = 32'h8001_0000;

    // gpio register offsets
    localparam logic [7:0] GPIO_OUT_OFS = 8'h00;
    localparam logic [7:0] GPIO_ENA_OFS = 8'h04;
    localparam logic [7:0] GPIO_INP_OFS = 8'h08;

    // uart register offsets, bit 6 set
    localparam logic [7:0] UART_TXD_OFS = 8'h40;
    localparam logic [7:0] UART_STS_OFS = 8'h44;

endpackage: mouse_soc_pkg

// ==== soc_interconnect.sv ====
// bus interconnect steering requests to memory or peripherals and merging responses
module soc_interconnect (
    // system signals
    input  logic                    clk,
    input  logic                    rst,
    // manager side
    input  logic                    vld,
    input  mouse_soc_pkg::tcb_req_t req,
    output logic                    rdy,
    output mouse_soc_pkg::tcb_rsp_t rsp,
    // data memory
    output logic                    mem_vld,
    input  logic                    mem_rdy,
    input  mouse_soc_pkg::tcb_rsp_t mem_rsp,
    // peripherals
    output logic                    per_vld,
    input  logic                    per_rdy,
    input  mouse_soc_pkg::tcb_rsp_t per_rsp
);

    import mouse_soc_pkg::*;

    // record of the target accepted in the last transfer
    typedef struct packed {
        logic mem;
        logic per;
        logic err;
    } rsp_sel_t;

    logic     sel_mem;
    logic     sel_per;
    rsp_sel_t sel_q;

////////////////////////////////////////////////////////////////////////////
// address decoder
////////////////////////////////////////////////////////////////////////////

    // 64kB windows, upper half of address only
    assign sel_mem = (req.adr[XLEN-1:16] == MEM_BASE[XLEN-1:16]);
    assign sel_per = (req.adr[XLEN-1:16] == PER_BASE[XLEN-1:16]);

    // per target valid
    assign mem_vld = vld & sel_mem;
    assign per_vld = vld & sel_per;

    // ready from selected target
    // unmapped space never stalls
    always_comb begin
        if (sel_mem) begin
            rdy = mem_rdy;
        end else if (sel_per) begin
            rdy = per_rdy;
        end else begin
            rdy = 1'b1;
        end
    end

////////////////////////////////////////////////////////////////////////////
// response path
////////////////////////////////////////////////////////////////////////////

    // remember where the transfer went
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q <= '0;
        end else if (vld & rdy) begin
            sel_q.mem <= sel_mem;
            sel_q.per <= sel_per;
            sel_q.err <= ~sel_mem & ~sel_per;
        end
    end

    // response mux, error reply carries zero data
    always_comb begin
        if (sel_q.mem) begin
            rsp = mem_rsp;
        end else if (sel_q.per) begin
            rsp = per_rsp;
        end else begin
            rsp.rdt = '0;
            rsp.err = sel_q.err;
        end
    end

endmodule: soc_interconnect

// ==== soc_memory.sv ====
// single port data memory with log-size to byte enable conversion
module soc_memory #(
    // size in bytes
    parameter int unsigned MEM_SIZ = 4096
)(
    input  logic                    clk,
    // bus port
    input  logic                    vld,
    input  mouse_soc_pkg::tcb_req_t req,
    output logic                    rdy,
    output mouse_soc_pkg::tcb_rsp_t rsp
);

    import mouse_soc_pkg::*;

    // byte address width and word count
    localparam int unsigned MEM_ADR = $clog2(MEM_SIZ);
    localparam int unsigned MEM_WRD = MEM_SIZ / 4;

    logic [XLEN-1:0]    mem [0:MEM_WRD-1];
    logic [MEM_ADR-3:0] idx;
    logic [3:0]         ben;
    logic               mis;
    logic [XLEN-1:0]    wdt;

    // word index
    assign idx = req.adr[MEM_ADR-1:2];

    // byte enables and alignment check
    always_comb begin
        case (req.siz)
            SIZ_BYTE: begin
                ben = 4'b0001 << req.adr[1:0];
                mis = 1'b0;
            end
            SIZ_HALF: begin
                ben = 4'b0011 << req.adr[1:0];
                mis = req.adr[0];
            end
            SIZ_WORD: begin
                ben = 4'b1111;
                mis = |req.adr[1:0];
            end
            // reserved size code
            default: begin
                ben = 4'b0000;
                mis = 1'b1;
            end
        endcase
    end

    // move right aligned data into its lanes
    assign wdt = req.wdt << (8 * req.adr[1:0]);

    // never stalls
    assign rdy = vld;

    // lane writes, misaligned access leaves memory alone
    always_ff @(posedge clk) begin
        if (vld & req.wen & ~mis) begin
            for (int i = 0; i < 4; i++) begin
                if (ben[i]) mem[idx][8*i+:8] <= wdt[8*i+:8];
            end
        end
    end

    // registered read of the whole word
    always_ff @(posedge clk) begin
        if (vld) begin
            rsp.rdt <= mem[idx];
            rsp.err <= mis;
        end
    end

endmodule: soc_memory

// ==== soc_gpio.sv ====
// gpio controller with output, output enable and synchronized input registers
module soc_gpio #(
    // gpio width
    parameter int unsigned GPIO_DAT = 32
)(
    // system signals
    input  logic                    clk,
    input  logic                    rst,
    // bus port, never stalls
    input  logic                    vld,
    input  mouse_soc_pkg::tcb_req_t req,
    output mouse_soc_pkg::tcb_rsp_t rsp,
    // pins
    output logic [GPIO_DAT-1:0]     gpio_o,
    output logic [GPIO_DAT-1:0]     gpio_e,
    input  logic [GPIO_DAT-1:0]     gpio_i
);

    import mouse_soc_pkg::*;

    logic [GPIO_DAT-1:0] inp_s1;
    logic [GPIO_DAT-1:0] inp_s2;
    logic [7:0]          ofs;

    // register offset within the block
    assign ofs = req.adr[7:0];

    // two flop input synchronizer
    always_ff @(posedge clk) begin
        inp_s1 <= gpio_i;
        inp_s2 <= inp_s1;
    end

    // output and enable registers
    always_ff @(posedge clk) begin
        if (rst) begin
            gpio_o <= '0;
            gpio_e <= '0;
        end else if (vld & req.wen) begin
            if (ofs == GPIO_OUT_OFS) gpio_o <= req.wdt[GPIO_DAT-1:0];
            if (ofs == GPIO_ENA_OFS) gpio_e <= req.wdt[GPIO_DAT-1:0];
        end
    end

    // read data, input register ignores writes
    always_ff @(posedge clk) begin
        if (vld) begin
            rsp.err <= 1'b0;
            case (ofs)
                GPIO_OUT_OFS: rsp.rdt <= XLEN'(gpio_o);
                GPIO_ENA_OFS: rsp.rdt <= XLEN'(gpio_e);
                GPIO_INP_OFS: rsp.rdt <= XLEN'(inp_s2);
                default: begin
                    // unused offset
                    rsp.rdt <= '0;
                    rsp.err <= 1'b1;
                end
            endcase
        end
    end

endmodule: soc_gpio

// ==== soc_uart_tx.sv ====
// 8N1 serial transmitter stalling data writes while a frame is in progress
module soc_uart_tx #(
    // clock cycles per serial bit
    parameter int unsigned UART_DIV = 434
)(
    // system signals
    input  logic                    clk,
    input  logic                    rst,
    // bus port
    input  logic                    vld,
    input  mouse_soc_pkg::tcb_req_t req,
    output logic                    rdy,
    output mouse_soc_pkg::tcb_rsp_t rsp,
    // serial output
    output logic                    uart_txd
);

    import mouse_soc_pkg::*;

    // baud divider width
    localparam int unsigned DIV_W = $clog2(UART_DIV);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } uart_state_e;

    uart_state_e      state;
    logic [DIV_W-1:0] div_cnt;
    logic [2:0]       bit_cnt;
    logic [7:0]       dat;
    logic             busy;
    logic             bit_end;
    logic             is_txd;
    logic             is_sts;
    logic             wr_txd;

    // register decode
    assign is_txd = (req.adr[7:0] == UART_TXD_OFS);
    assign is_sts = (req.adr[7:0] == UART_STS_OFS);
    assign wr_txd = vld & req.wen & is_txd;

    assign busy    = (state != IDLE);
    assign bit_end = (div_cnt == DIV_W'(UART_DIV - 1));

    // hold data writes until the frame is out
    assign rdy = ~(wr_txd & busy);

////////////////////////////////////////////////////////////////////////////
// frame FSM
////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            uart_txd <= 1'b1;
        end else begin
            // baud divider runs only during a frame
            if (busy) div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
            case (state)
                IDLE: begin
                    if (wr_txd) begin
                        // start bit from the next edge
                        state    <= START;
                        div_cnt  <= '0;
                        uart_txd <= 1'b0;
                    end
                end
                START: begin
                    if (bit_end) begin
                        state    <= DATA;
                        bit_cnt  <= '0;
                        uart_txd <= dat[0];
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == 3'd7) begin
                            state    <= STOP;
                            uart_txd <= 1'b1;
                        end else begin
                            bit_cnt  <= bit_cnt + 1'b1;
                            uart_txd <= dat[1];
                        end
                    end
                end
                STOP: begin
                    // busy drops here
                    if (bit_end) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // data shifter, lsb first
    always_ff @(posedge clk) begin
        if (wr_txd & ~busy) begin
            dat <= req.wdt[7:0];
        end else if ((state == DATA) & bit_end) begin
            dat <= dat >> 1;
        end
    end

    // response, status returns busy in bit 0
    always_ff @(posedge clk) begin
        if (vld & rdy) begin
            rsp.rdt <= is_sts ? XLEN'(busy) : '0;
            rsp.err <= ~(is_txd | is_sts);
        end
    end

endmodule: soc_uart_tx

// ==== soc_peripherals.sv ====
// peripheral block decoding gpio and uart registers and muxing their replies
module soc_peripherals #(
    // gpio width
    parameter int unsigned GPIO_DAT = 32,
    // clock cycles per serial bit
    parameter int unsigned UART_DIV = 434
)(
    // system signals
    input  logic                    clk,
    input  logic                    rst,
    // bus port
    input  logic                    vld,
    input  mouse_soc_pkg::tcb_req_t req,
    output logic                    rdy,
    output mouse_soc_pkg::tcb_rsp_t rsp,
    // gpio pins
    output logic [GPIO_DAT-1:0]     gpio_o,
    output logic [GPIO_DAT-1:0]     gpio_e,
    input  logic [GPIO_DAT-1:0]     gpio_i,
    // serial output
    output logic                    uart_txd
);

    import mouse_soc_pkg::*;

    logic     sel_uart;
    logic     sel_q;
    logic     gpio_vld;
    logic     uart_vld;
    logic     uart_rdy;
    tcb_rsp_t gpio_rsp;
    tcb_rsp_t uart_rsp;

    // 0x00~0x3f gpio, 0x40~0x7f uart
    assign sel_uart = req.adr[6];
    assign gpio_vld = vld & ~sel_uart;
    assign uart_vld = vld &  sel_uart;

    // gpio is always ready, only uart stalls
    assign rdy = uart_rdy;

    // selection for the response cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q <= 1'b0;
        end else if (vld & rdy) begin
            sel_q <= sel_uart;
        end
    end

    assign rsp = sel_q ? uart_rsp : gpio_rsp;

////////////////////////////////////////////////////////////////////////////
// leaves
////////////////////////////////////////////////////////////////////////////

    soc_gpio #(
        .GPIO_DAT (GPIO_DAT)
    ) gpio (
        .clk    (clk),
        .rst    (rst),
        .vld    (gpio_vld),
        .req    (req),
        .rsp    (gpio_rsp),
        .gpio_o (gpio_o),
        .gpio_e (gpio_e),
        .gpio_i (gpio_i)
    );

    soc_uart_tx #(
        .UART_DIV (UART_DIV)
    ) uart (
        .clk      (clk),
        .rst      (rst),
        .vld      (uart_vld),
        .req      (req),
        .rdy      (uart_rdy),
        .rsp      (uart_rsp),
        .uart_txd (uart_txd)
    );

endmodule: soc_peripherals

// ==== mouse_soc_top.sv ====
// mouse soc fabric top level joining interconnect, data memory and peripherals
module mouse_soc_top #(
    // data memory size in bytes
    parameter int unsigned MEM_SIZ  = 4096,
    // gpio width
    parameter int unsigned GPIO_DAT = 32,
    // clock cycles per serial bit
    parameter int unsigned UART_DIV = 434
)(
    // system signals
    input  logic                    clk,
    input  logic                    rst,
    // external manager port
    input  logic                    vld,
    input  mouse_soc_pkg::tcb_req_t req,
    output logic                    rdy,
    output mouse_soc_pkg::tcb_rsp_t rsp,
    // gpio
    output logic [GPIO_DAT-1:0]     gpio_o,
    output logic [GPIO_DAT-1:0]     gpio_e,
    input  logic [GPIO_DAT-1:0]     gpio_i,
    // uart
    output logic                    uart_txd
);

    import mouse_soc_pkg::*;

    // target side handshakes
    logic     mem_vld;
    logic     mem_rdy;
    tcb_rsp_t mem_rsp;
    logic     per_vld;
    logic     per_rdy;
    tcb_rsp_t per_rsp;

////////////////////////////////////////////////////////////////////////////
// interconnect
////////////////////////////////////////////////////////////////////////////

    soc_interconnect ic (
        .clk     (clk),
        .rst     (rst),
        .vld     (vld),
        .req     (req),
        .rdy     (rdy),
        .rsp     (rsp),
        .mem_vld (mem_vld),
        .mem_rdy (mem_rdy),
        .mem_rsp (mem_rsp),
        .per_vld (per_vld),
        .per_rdy (per_rdy),
        .per_rsp (per_rsp)
    );

////////////////////////////////////////////////////////////////////////////
// targets
////////////////////////////////////////////////////////////////////////////

    // request payload is shared, only vld is steered
    soc_memory #(
        .MEM_SIZ (MEM_SIZ)
    ) mem (
        .clk (clk),
        .vld (mem_vld),
        .req (req),
        .rdy (mem_rdy),
        .rsp (mem_rsp)
    );

    soc_peripherals #(
        .GPIO_DAT (GPIO_DAT),
        .UART_DIV (UART_DIV)
    ) per (
        .clk      (clk),
        .rst      (rst),
        .vld      (per_vld),
        .req      (req),
        .rdy      (per_rdy),
        .rsp      (per_rsp),
        .gpio_o   (gpio_o),
        .gpio_e   (gpio_e),
        .gpio_i   (gpio_i),
        .uart_txd (uart_txd)
    );

endmodule: mouse_soc_top

// ==== tb_mouse_soc_top.sv ====
// random-stimulus testbench for the mouse soc fabric with memory, gpio and uart models
module tb_mouse_soc_top;

    timeunit 1ns;
    timeprecision 1ps;

    import mouse_soc_pkg::*;

    // dut configuration
    localparam int unsigned MEM_SIZ  = 4096;
    localparam int unsigned GPIO_DAT = 32;
    localparam int unsigned UART_DIV = 8;

    // clock period and drive delay in ns
    localparam int unsigned CLK_PER = 40;
    localparam int unsigned DRV_DLY = 2;
    // random seed
    localparam int unsigned SEED    = 38;

    // test lengths
    localparam int unsigned MEM_TST   = 512;
    localparam int unsigned N_MEM_RND = 200;
    localparam int unsigned N_MEM_MIS = 40;
    localparam int unsigned N_GPIO    = 10;
    localparam int unsigned N_UART    = 8;
    localparam int unsigned N_UNMAP   = 16;

    // upper bound of bus transfers over all tests
    localparam int unsigned NUM_TXN = MEM_TST / 4 + 2 * N_MEM_RND + 2 * N_MEM_MIS
                                    + 7 * N_GPIO + N_UART + N_UART / 2 + 1
                                    + N_UNMAP + MEM_TST / 4 + 1;

    // full register addresses
    localparam logic [XLEN-1:0] GPIO_OUT_ADR = PER_BASE | XLEN'(GPIO_OUT_OFS);
    localparam logic [XLEN-1:0] GPIO_ENA_ADR = PER_BASE | XLEN'(GPIO_ENA_OFS);
    localparam logic [XLEN-1:0] GPIO_INP_ADR = PER_BASE | XLEN'(GPIO_INP_OFS);
    localparam logic [XLEN-1:0] UART_TXD_ADR = PER_BASE | XLEN'(UART_TXD_OFS);
    localparam logic [XLEN-1:0] UART_STS_ADR = PER_BASE | XLEN'(UART_STS_OFS);

    logic                clk;
    logic                rst;
    logic                vld;
    tcb_req_t            req;
    logic                rdy;
    tcb_rsp_t            rsp;
    logic [GPIO_DAT-1:0] gpio_o;
    logic [GPIO_DAT-1:0] gpio_e;
    logic [GPIO_DAT-1:0] gpio_i;
    logic                uart_txd;

    // reference model
    logic [7:0]          mem_ref [0:MEM_TST-1];
    logic [GPIO_DAT-1:0] gpio_o_ref;
    logic [GPIO_DAT-1:0] gpio_e_ref;
    logic [7:0]          uart_ref [$];

    // bookkeeping
    int unsigned err_cnt     = 0;
    int unsigned txn_cnt     = 0;
    int unsigned uart_tx_cnt = 0;
    int unsigned uart_rx_cnt = 0;

    mouse_soc_top #(
        .MEM_SIZ  (MEM_SIZ),
        .GPIO_DAT (GPIO_DAT),
        .UART_DIV (UART_DIV)
    ) UUT (
        .clk      (clk),
        .rst      (rst),
        .vld      (vld),
        .req      (req),
        .rdy      (rdy),
        .rsp      (rsp),
        .gpio_o   (gpio_o),
        .gpio_e   (gpio_e),
        .gpio_i   (gpio_i),
        .uart_txd (uart_txd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PER / 2) clk = ~clk;
    end

////////////////////////////////////////////////////////////////////////////
// helpers
////////////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] adr,
                                   input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
        err_cnt++;
        $display("[FAIL] %s adr=%h got=%h exp=%h at %0t", name, adr, got, exp, $time);
    endtask

    task automatic report_error(input string msg);
        err_cnt++;
        $display("ERROR: %s at %0t", msg, $time);
    endtask

    task automatic print_summary();
        $display("summary: %0d transfers, %0d uart bytes sent, %0d received, %0d errors",
                 txn_cnt, uart_tx_cnt, uart_rx_cnt, err_cnt);
    endtask

    function automatic tcb_siz_e rand_siz();
        case ($urandom_range(2))
            0: return SIZ_BYTE;
            1: return SIZ_HALF;
            default: return SIZ_WORD;
        endcase
    endfunction

    // little endian word from the byte model
    function automatic logic [XLEN-1:0] ref_word(input int unsigned ofs);
        int unsigned a;
        a = ofs & ~32'd3;
        return {mem_ref[a+3], mem_ref[a+2], mem_ref[a+1], mem_ref[a]};
    endfunction

    // right aligned data lands at ofs upward
    task automatic ref_write(input int unsigned ofs, input tcb_siz_e siz,
                             input logic [XLEN-1:0] wdt);
        int unsigned n;
        int unsigned i;
        n = 1 << siz;
        for (i = 0; i < n; i++) begin
            mem_ref[ofs+i] = wdt[8*i+:8];
        end
    endtask

    // one transfer with its response taken in the following cycle
    task automatic bus_xfer(input logic wen, input logic [XLEN-1:0] adr, input tcb_siz_e siz,
                            input logic [XLEN-1:0] wdt, output tcb_rsp_t rs);
        logic        stall_ok;
        logic        flagged;
        int unsigned stall_cnt;
        @(posedge clk);
        #DRV_DLY;
        vld       = 1'b1;
        req.wen   = wen;
        req.adr   = adr;
        req.siz   = siz;
        req.wdt   = wdt;
        // only a uart data write may see back-pressure
        stall_ok  = wen && (adr == UART_TXD_ADR);
        flagged   = 1'b0;
        stall_cnt = 0;
        @(negedge clk);
        while (!rdy) begin
            stall_cnt++;
            if (!flagged && !stall_ok) begin
                report_error($sformatf("rdy low for a request that never stalls, adr %h", adr));
                flagged = 1'b1;
            end
            if (!flagged && (stall_cnt > 10 * UART_DIV + 2)) begin
                report_error("uart write held past the end of the current frame");
                flagged = 1'b1;
            end
            @(negedge clk);
        end
        // transfer edge
        @(posedge clk);
        #DRV_DLY;
        vld = 1'b0;
        @(negedge clk);
        rs = rsp;
        txn_cnt++;
    endtask

////////////////////////////////////////////////////////////////////////////
// serial line monitor
////////////////////////////////////////////////////////////////////////////

    initial begin : serial_monitor
        logic [7:0] rx;
        logic [7:0] rx_exp;
        int unsigned i;
        wait (rst === 1'b0);
        forever begin
            @(negedge uart_txd);
            // half a bit to the start bit center
            repeat (UART_DIV / 2) @(negedge clk);
            if (uart_txd !== 1'b0) begin
                report_error("start bit not low at its center");
            end
            for (i = 0; i < 8; i++) begin
                repeat (UART_DIV) @(negedge clk);
                rx[i] = uart_txd;
            end
            repeat (UART_DIV) @(negedge clk);
            if (uart_txd !== 1'b1) begin
                report_error("stop bit not high at its center");
            end
            uart_rx_cnt++;
            if (uart_ref.size() == 0) begin
                report_error("serial byte received while none was expected");
            end else begin
                rx_exp = uart_ref.pop_front();
                if (rx !== rx_exp) begin
                    report_mismatch("uart_txd byte", UART_TXD_ADR, XLEN'(rx), XLEN'(rx_exp));
                end
            end
        end
    end

    // run length bound from the transfer count
    initial begin : watchdog
        repeat (NUM_TXN * 12 * UART_DIV + 2000) @(posedge clk);
        $display("ERROR: watchdog expired before the tests completed");
        print_summary();
        $display("TEST FAILED");
        $finish;
    end

////////////////////////////////////////////////////////////////////////////
// stimulus and checks
////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        tcb_rsp_t        rs;
        tcb_siz_e        siz;
        logic [XLEN-1:0] wdt;
        logic [XLEN-1:0] adr;
        int unsigned     ofs;
        int unsigned     n;
        int unsigned     kind;
        void'($urandom(SEED));
        rst    = 1'b1;
        vld    = 1'b0;
        req    = '0;
        gpio_i = '0;
        repeat (16) @(posedge clk);
        #DRV_DLY;
        rst = 1'b0;

        // idle state after reset
        @(negedge clk);
        if (uart_txd !== 1'b1) report_mismatch("uart_txd", '0, XLEN'(uart_txd), 32'd1);
        if (gpio_o !== '0) report_mismatch("gpio_o", '0, XLEN'(gpio_o), '0);
        if (gpio_e !== '0) report_mismatch("gpio_e", '0, XLEN'(gpio_e), '0);
        if (rsp.err !== 1'b0) report_mismatch("rsp.err", '0, XLEN'(rsp.err), '0);

        // fill the test window so every read is defined
        for (n = 0; n < MEM_TST / 4; n++) begin
            wdt = $urandom();
            bus_xfer(1'b1, MEM_BASE + 4 * n, SIZ_WORD, wdt, rs);
            ref_write(4 * n, SIZ_WORD, wdt);
            if (rs.err !== 1'b0) report_mismatch("rsp.err", MEM_BASE + 4 * n, rs.err, 0);
        end

        // aligned random writes with junk data above the access size
        for (n = 0; n < N_MEM_RND; n++) begin
            siz = rand_siz();
            ofs = $urandom_range(MEM_TST - 1) & ~((1 << siz) - 1);
            wdt = $urandom();
            bus_xfer(1'b1, MEM_BASE + ofs, siz, wdt, rs);
            ref_write(ofs, siz, wdt);
            if (rs.err !== 1'b0) report_mismatch("rsp.err", MEM_BASE + ofs, rs.err, 0);
        end

        for (n = 0; n < N_MEM_RND; n++) begin
            siz = rand_siz();
            ofs = $urandom_range(MEM_TST - 1) & ~((1 << siz) - 1);
            bus_xfer(1'b0, MEM_BASE + ofs, siz, '0, rs);
            if (rs.rdt !== ref_word(ofs)) report_mismatch("rsp.rdt", MEM_BASE + ofs, rs.rdt,
                                                          ref_word(ofs));
            if (rs.err !== 1'b0) report_mismatch("rsp.err", MEM_BASE + ofs, rs.err, 0);
        end

        // misaligned half and word
        for (n = 0; n < N_MEM_MIS; n++) begin
            ofs = $urandom_range(MEM_TST - 1);
            if ($urandom_range(1) == 0) begin
                siz = SIZ_HALF;
                ofs = ofs | 1;
            end else begin
                siz = SIZ_WORD;
                ofs = (ofs & ~32'd3) | $urandom_range(3, 1);
            end
            bus_xfer($urandom_range(1), MEM_BASE + ofs, siz, $urandom(), rs);
            if (rs.err !== 1'b1) report_mismatch("rsp.err", MEM_BASE + ofs, rs.err, 1);
            // word must be untouched
            bus_xfer(1'b0, MEM_BASE + (ofs & ~32'd3), SIZ_WORD, '0, rs);
            if (rs.rdt !== ref_word(ofs)) report_mismatch("rsp.rdt", MEM_BASE + ofs, rs.rdt,
                                                          ref_word(ofs));
            if (rs.err !== 1'b0) report_mismatch("rsp.err", MEM_BASE + ofs, rs.err, 0);
        end

        // gpio outputs, enables and input sampling
        for (n = 0; n < N_GPIO; n++) begin
            gpio_o_ref = $urandom();
            bus_xfer(1'b1, GPIO_OUT_ADR, SIZ_WORD, gpio_o_ref, rs);
            if (rs.err !== 1'b0) report_mismatch("rsp.err", GPIO_OUT_ADR, rs.err, 0);
            if (gpio_o !== gpio_o_ref) report_mismatch("gpio_o", GPIO_OUT_ADR, gpio_o,
                                                       gpio_o_ref);
            gpio_e_ref = $urandom();
            bus_xfer(1'b1, GPIO_ENA_ADR, SIZ_WORD, gpio_e_ref, rs);
            if (rs.err !== 1'b0) report_mismatch("rsp.err", GPIO_ENA_ADR, rs.err, 0);
            if (gpio_e !== gpio_e_ref) report_mismatch("gpio_e", GPIO_ENA_ADR, gpio_e,
                                                       gpio_e_ref);
            bus_xfer(1'b0, GPIO_OUT_ADR, SIZ_WORD, '0, rs);
            if (rs.rdt !== gpio_o_ref) report_mismatch("rsp.rdt", GPIO_OUT_ADR, rs.rdt,
                                                       gpio_o_ref);
            bus_xfer(1'b0, GPIO_ENA_ADR, SIZ_WORD, '0, rs);
            if (rs.rdt !== gpio_e_ref) report_mismatch("rsp.rdt", GPIO_ENA_ADR, rs.rdt,
                                                       gpio_e_ref);
            // new input held through the synchronizer
            @(posedge clk);
            #DRV_DLY;
            gpio_i = $urandom();
            repeat (3) @(posedge clk);
            bus_xfer(1'b0, GPIO_INP_ADR, SIZ_WORD, '0, rs);
            if (rs.rdt !== gpio_i) report_mismatch("rsp.rdt", GPIO_INP_ADR, rs.rdt, gpio_i);
            if (rs.err !== 1'b0) report_mismatch("rsp.err", GPIO_INP_ADR, rs.err, 0);
            // input register is read only
            bus_xfer(1'b1, GPIO_INP_ADR, SIZ_WORD, $urandom(), rs);
            if (rs.err !== 1'b0) report_mismatch("rsp.err", GPIO_INP_ADR, rs.err, 0);
            if (gpio_o !== gpio_o_ref) report_mismatch("gpio_o", GPIO_INP_ADR, gpio_o,
                                                       gpio_o_ref);
            if (gpio_e !== gpio_e_ref) report_mismatch("gpio_e", GPIO_INP_ADR, gpio_e,
                                                       gpio_e_ref);
            bus_xfer(1'b0, GPIO_INP_ADR, SIZ_WORD, '0, rs);
            if (rs.rdt !== gpio_i) report_mismatch("rsp.rdt", GPIO_INP_ADR, rs.rdt, gpio_i);
        end

        // back to back uart bytes where the later ones stall on rdy
        for (n = 0; n < N_UART; n++) begin
            wdt = $urandom();
            bus_xfer(1'b1, UART_TXD_ADR, SIZ_WORD, wdt, rs);
            uart_ref.push_back(wdt[7:0]);
            uart_tx_cnt++;
            if (rs.err !== 1'b0) report_mismatch("rsp.err", UART_TXD_ADR, rs.err, 0);
            // busy while the new frame is on the line
            if (n % 2 == 0) begin
                bus_xfer(1'b0, UART_STS_ADR, SIZ_WORD, '0, rs);
                if (rs.rdt !== 32'd1) report_mismatch("rsp.rdt", UART_STS_ADR, rs.rdt, 1);
            end
        end
        wait (uart_rx_cnt == uart_tx_cnt);
        // rest of the last stop bit
        repeat (2 * UART_DIV) @(posedge clk);
        bus_xfer(1'b0, UART_STS_ADR, SIZ_WORD, '0, rs);
        if (rs.rdt !== 32'd0) report_mismatch("rsp.rdt", UART_STS_ADR, rs.rdt, 0);

        // unmapped space and unused peripheral offsets
        for (n = 0; n < N_UNMAP; n++) begin
            kind = $urandom_range(3);
            ofs  = $urandom_range(MEM_TST - 1) & ~32'd3;
            case (kind)
                0: begin
                    adr = $urandom();
                    if ((adr[31:16] == MEM_BASE[31:16]) || (adr[31:16] == PER_BASE[31:16]))
                        adr = adr ^ 32'h4000_0000;
                end
                // looks like a memory offset in the next window
                1: adr = 32'h8002_0000 | ofs;
                2: adr = PER_BASE | (32'h0c + 4 * $urandom_range(12));
                default: adr = PER_BASE | (32'h48 + 4 * $urandom_range(13));
            endcase
            bus_xfer($urandom_range(1), adr, SIZ_WORD, $urandom(), rs);
            if (rs.err !== 1'b1) report_mismatch("rsp.err", adr, rs.err, 1);
            if ((kind < 2) && (rs.rdt !== '0)) report_mismatch("rsp.rdt", adr, rs.rdt, 0);
        end
        // nothing may have changed
        for (n = 0; n < MEM_TST / 4; n++) begin
            bus_xfer(1'b0, MEM_BASE + 4 * n, SIZ_WORD, '0, rs);
            if (rs.rdt !== ref_word(4 * n)) report_mismatch("rsp.rdt", MEM_BASE + 4 * n,
                                                            rs.rdt, ref_word(4 * n));
        end
        if (gpio_o !== gpio_o_ref) report_mismatch("gpio_o", '0, gpio_o, gpio_o_ref);
        if (gpio_e !== gpio_e_ref) report_mismatch("gpio_e", '0, gpio_e, gpio_e_ref);
        bus_xfer(1'b0, UART_STS_ADR, SIZ_WORD, '0, rs);
        if (rs.rdt !== 32'd0) report_mismatch("rsp.rdt", UART_STS_ADR, rs.rdt, 0);
        if (uart_txd !== 1'b1) report_mismatch("uart_txd", '0, XLEN'(uart_txd), 32'd1);

        // give a stray frame time to show up on the monitor
        repeat (12 * UART_DIV) @(posedge clk);
        if (uart_ref.size() != 0) report_error("expected uart bytes never left the serial line");
        if (uart_rx_cnt != uart_tx_cnt) report_error("serial byte count differs from writes");

        print_summary();
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule: tb_mouse_soc_top

// ==== mouse_soc_top.f ====
mouse_soc_pkg.sv
soc_interconnect.sv
soc_memory.sv
soc_gpio.sv
soc_uart_tx.sv
soc_peripherals.sv
mouse_soc_top.sv
tb_mouse_soc_top.sv
